/* verilog/l2cache_macros.svh */
`ifndef L2CACHE_MACROS_SVH
`define L2CACHE_MACROS_SVH

// Cache geometry for the two-way L2.

// Number of sets per way.
`define L2_SETS 8

// Set index taken from the address just above the line offset.
`define L2_INDEX_BITS 3

// Byte offset within a 32-byte line.
`define L2_OFFSET_BITS 5

// Tag is whatever remains of the 16-bit address.
`define L2_TAG_BITS 8

// Full line as moved on both the upstream and memory sides.
`define L2_LINE_BITS 256

`endif

/* verilog/l2cache_pkg.sv */
`include "l2cache_macros.svh"

package l2cache_pkg;

    // Byte address, split as tag, set index and line offset.
    typedef logic [`L2_TAG_BITS+`L2_INDEX_BITS+`L2_OFFSET_BITS-1:0] l2_word;

    // One cache line.
    typedef logic [`L2_LINE_BITS-1:0] cache_line;

    // Stored tag of one way.
    typedef logic [`L2_TAG_BITS-1:0] l2_tag;

    // Controller states.
    // A miss runs write back (if dirty), allocate, update cache, complete.
    typedef enum logic [2:0] {
        s_idle,
        s_write_back,
        s_allocate,
        s_update_cache,
        s_pmem_complete
    } l2cache_state_e;

endpackage : l2cache_pkg

/* verilog/l2cache_data_array.sv */
`timescale 1ns/10ps
`include "l2cache_macros.svh"

module l2cache_data_array
(
    input  logic                       clk,
    input  logic                       write,
    input  logic [`L2_INDEX_BITS-1:0]  index,
    input  l2cache_pkg::cache_line     datain,
    output l2cache_pkg::cache_line     dataout
);

    // Line storage for one way.
    // Valid bits in the datapath decide whether an entry means anything.
    l2cache_pkg::cache_line lines [`L2_SETS];

    always_ff @(posedge clk)
    begin
        if (write)
        begin
            lines[index] <= datain;
        end
    end

    // Asynchronous read so hits can respond in the same cycle.
    assign dataout = lines[index];

endmodule : l2cache_data_array

/* verilog/l2cache_datapath.sv */
`timescale 1ns/10ps
`include "l2cache_macros.svh"

module l2cache_datapath
(
    input  logic                    clk,
    input  logic                    reset,

    input  l2cache_pkg::l2_word     mem_address,
    input  l2cache_pkg::cache_line  mem_wdata,
    input  l2cache_pkg::cache_line  pmem_rdata,

    input  logic                    data0write,
    input  logic                    data1write,
    input  logic                    tag0write,
    input  logic                    tag1write,
    input  logic                    valid0write,
    input  logic                    valid1write,
    input  logic                    dirty0write,
    input  logic                    dirty1write,
    input  logic                    dirty0_in,
    input  logic                    dirty1_in,
    input  logic                    lru_write,
    input  logic                    lru_in,
    input  logic                    rwmux_sel,
    input  logic                    pmemmux_sel,

    output l2cache_pkg::cache_line  mem_rdata,
    output l2cache_pkg::cache_line  pmem_wdata,
    output l2cache_pkg::l2_word     pmem_address,
    output logic                    hit,
    output logic                    way0and_out,
    output logic                    lru_out,
    output logic                    dirtymux_out
);

    logic [`L2_INDEX_BITS-1:0] index;
    l2cache_pkg::l2_tag        req_tag;
    l2cache_pkg::l2_tag        victim_tag;
    l2cache_pkg::cache_line    write_line;
    l2cache_pkg::cache_line    line0;
    l2cache_pkg::cache_line    line1;
    logic                      hit0;
    logic                      hit1;
    logic                      read_way;

    // Per-set tag storage, guarded by the valid bits.
    l2cache_pkg::l2_tag        tag0 [`L2_SETS];
    l2cache_pkg::l2_tag        tag1 [`L2_SETS];

    logic [`L2_SETS-1:0]       valid0;
    logic [`L2_SETS-1:0]       valid1;
    logic [`L2_SETS-1:0]       dirty0;
    logic [`L2_SETS-1:0]       dirty1;
    // One bit per set naming the victim way.
    logic [`L2_SETS-1:0]       lru;

    assign index   = mem_address[`L2_OFFSET_BITS +: `L2_INDEX_BITS];
    assign req_tag = mem_address[`L2_OFFSET_BITS+`L2_INDEX_BITS +: `L2_TAG_BITS];

    // Full-line writes come from upstream on a store, else from memory.
    assign write_line = rwmux_sel ? mem_wdata : pmem_rdata;

    l2cache_data_array way0_data
    (
        .clk     (clk),
        .write   (data0write),
        .index   (index),
        .datain  (write_line),
        .dataout (line0)
    );

    l2cache_data_array way1_data
    (
        .clk     (clk),
        .write   (data1write),
        .index   (index),
        .datain  (write_line),
        .dataout (line1)
    );

    always_ff @(posedge clk)
    begin
        if (tag0write)
        begin
            tag0[index] <= req_tag;
        end
        if (tag1write)
        begin
            tag1[index] <= req_tag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid0 <= '0;
            valid1 <= '0;
            dirty0 <= '0;
            dirty1 <= '0;
            lru    <= '0;
        end
        else
        begin
            if (valid0write)
                valid0[index] <= 1'b1;
            if (valid1write)
                valid1[index] <= 1'b1;
            if (dirty0write)
                dirty0[index] <= dirty0_in;
            if (dirty1write)
                dirty1[index] <= dirty1_in;
            if (lru_write)
                lru[index] <= lru_in;
        end
    end

    // Hit detection.
    assign hit0        = valid0[index] && (tag0[index] == req_tag);
    assign hit1        = valid1[index] && (tag1[index] == req_tag);
    assign hit         = hit0 | hit1;
    assign way0and_out = hit0;

    // Victim selection.
    assign lru_out      = lru[index];
    assign dirtymux_out = lru_out ? (valid1[index] & dirty1[index])
                                  : (valid0[index] & dirty0[index]);
    assign victim_tag   = lru_out ? tag1[index] : tag0[index];

    // On a hit read the matching way; otherwise the way being allocated.
    assign read_way  = hit ? ~hit0 : lru_out;
    assign mem_rdata = read_way ? line1 : line0;

    assign pmem_wdata = lru_out ? line1 : line0;

    // Write-back goes to the victim's line, fills come from the request's line.
    assign pmem_address = pmemmux_sel
                        ? {victim_tag, index, {`L2_OFFSET_BITS{1'b0}}}
                        : {req_tag, index, {`L2_OFFSET_BITS{1'b0}}};

endmodule : l2cache_datapath

/* verilog/l2cache_control.sv */
`timescale 1ns/10ps

module l2cache_control
(
    input  logic clk,
    input  logic reset,

    input  logic mem_read,
    input  logic mem_write,
    input  logic hit,
    input  logic way0and_out,
    input  logic lru_out,
    input  logic dirtymux_out,
    input  logic pmem_resp,

    output logic data0write,
    output logic data1write,
    output logic tag0write,
    output logic tag1write,
    output logic valid0write,
    output logic valid1write,
    output logic dirty0write,
    output logic dirty1write,
    output logic dirty0_in,
    output logic dirty1_in,
    output logic lru_write,
    output logic lru_in,
    output logic rwmux_sel,
    output logic pmemmux_sel,
    output logic mem_resp,
    output logic pmem_read,
    output logic pmem_write
);

    l2cache_pkg::l2cache_state_e state;
    l2cache_pkg::l2cache_state_e next_state;
    logic                        req;

    assign req = mem_read | mem_write;

    always_comb
    begin : state_actions
        data0write  = 1'b0;
        data1write  = 1'b0;
        tag0write   = 1'b0;
        tag1write   = 1'b0;
        valid0write = 1'b0;
        valid1write = 1'b0;
        dirty0write = 1'b0;
        dirty1write = 1'b0;
        dirty0_in   = 1'b0;
        dirty1_in   = 1'b0;
        lru_write   = 1'b0;
        lru_in      = 1'b0;
        rwmux_sel   = 1'b0;
        pmemmux_sel = 1'b0;
        mem_resp    = 1'b0;
        pmem_read   = 1'b0;
        pmem_write  = 1'b0;

        case (state)
            l2cache_pkg::s_idle:
            begin
                if (req && hit)
                begin
                    // The way just used stops being the victim.
                    mem_resp  = 1'b1;
                    lru_write = 1'b1;
                    lru_in    = way0and_out;
                    if (mem_write)
                    begin
                        rwmux_sel = 1'b1;
                        if (way0and_out)
                        begin
                            data0write  = 1'b1;
                            dirty0write = 1'b1;
                            dirty0_in   = 1'b1;
                        end
                        else
                        begin
                            data1write  = 1'b1;
                            dirty1write = 1'b1;
                            dirty1_in   = 1'b1;
                        end
                    end
                end
            end

            l2cache_pkg::s_write_back:
            begin
                pmem_write  = 1'b1;
                pmemmux_sel = 1'b1;
            end

            l2cache_pkg::s_allocate:
            begin
                pmem_read = 1'b1;
                // Fill the victim way only once the memory data is valid.
                if (pmem_resp)
                begin
                    if (lru_out)
                    begin
                        data1write  = 1'b1;
                        tag1write   = 1'b1;
                        valid1write = 1'b1;
                        dirty1write = 1'b1;
                    end
                    else
                    begin
                        data0write  = 1'b1;
                        tag0write   = 1'b1;
                        valid0write = 1'b1;
                        dirty0write = 1'b1;
                    end
                end
            end

            l2cache_pkg::s_update_cache:
            begin
                // The new line now hits; point the LRU at the other way.
                lru_write = 1'b1;
                lru_in    = way0and_out;
            end

            l2cache_pkg::s_pmem_complete:
            begin
                mem_resp = 1'b1;
                if (mem_write)
                begin
                    // Store replaces the freshly allocated line.
                    rwmux_sel = 1'b1;
                    if (way0and_out)
                    begin
                        data0write  = 1'b1;
                        dirty0write = 1'b1;
                        dirty0_in   = 1'b1;
                    end
                    else
                    begin
                        data1write  = 1'b1;
                        dirty1write = 1'b1;
                        dirty1_in   = 1'b1;
                    end
                end
            end

            default:
            begin
            end
        endcase
    end

    always_comb
    begin : next_state_logic
        next_state = state;

        case (state)
            l2cache_pkg::s_idle:
            begin
                if (req && !hit)
                begin
                    if (dirtymux_out)
                        next_state = l2cache_pkg::s_write_back;
                    else
                        next_state = l2cache_pkg::s_allocate;
                end
            end
            l2cache_pkg::s_write_back:
            begin
                if (pmem_resp)
                    next_state = l2cache_pkg::s_allocate;
            end
            l2cache_pkg::s_allocate:
            begin
                if (pmem_resp)
                    next_state = l2cache_pkg::s_update_cache;
            end
            l2cache_pkg::s_update_cache:
            begin
                next_state = l2cache_pkg::s_pmem_complete;
            end
            l2cache_pkg::s_pmem_complete:
            begin
                next_state = l2cache_pkg::s_idle;
            end
            default:
            begin
                next_state = l2cache_pkg::s_idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= l2cache_pkg::s_idle;
        else
            state <= next_state;
    end

endmodule : l2cache_control

/* verilog/l2cache.sv */
`timescale 1ns/10ps

module l2cache
(
    input  logic                    clk,
    input  logic                    reset,

    // Upstream side.
    input  l2cache_pkg::l2_word     mem_address,
    input  logic                    mem_read,
    input  logic                    mem_write,
    input  l2cache_pkg::cache_line  mem_wdata,
    output l2cache_pkg::cache_line  mem_rdata,
    output logic                    mem_resp,

    // Physical memory side.
    output l2cache_pkg::l2_word     pmem_address,
    output logic                    pmem_read,
    output logic                    pmem_write,
    output l2cache_pkg::cache_line  pmem_wdata,
    input  l2cache_pkg::cache_line  pmem_rdata,
    input  logic                    pmem_resp
);

    logic data0write;
    logic data1write;
    logic tag0write;
    logic tag1write;
    logic valid0write;
    logic valid1write;
    logic dirty0write;
    logic dirty1write;
    logic dirty0_in;
    logic dirty1_in;
    logic lru_write;
    logic lru_in;
    logic rwmux_sel;
    logic pmemmux_sel;
    logic hit;
    logic way0and_out;
    logic lru_out;
    logic dirtymux_out;

    l2cache_control control
    (
        .clk          (clk),
        .reset        (reset),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .hit          (hit),
        .way0and_out  (way0and_out),
        .lru_out      (lru_out),
        .dirtymux_out (dirtymux_out),
        .pmem_resp    (pmem_resp),
        .data0write   (data0write),
        .data1write   (data1write),
        .tag0write    (tag0write),
        .tag1write    (tag1write),
        .valid0write  (valid0write),
        .valid1write  (valid1write),
        .dirty0write  (dirty0write),
        .dirty1write  (dirty1write),
        .dirty0_in    (dirty0_in),
        .dirty1_in    (dirty1_in),
        .lru_write    (lru_write),
        .lru_in       (lru_in),
        .rwmux_sel    (rwmux_sel),
        .pmemmux_sel  (pmemmux_sel),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write)
    );

    l2cache_datapath datapath
    (
        .clk          (clk),
        .reset        (reset),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .pmem_rdata   (pmem_rdata),
        .data0write   (data0write),
        .data1write   (data1write),
        .tag0write    (tag0write),
        .tag1write    (tag1write),
        .valid0write  (valid0write),
        .valid1write  (valid1write),
        .dirty0write  (dirty0write),
        .dirty1write  (dirty1write),
        .dirty0_in    (dirty0_in),
        .dirty1_in    (dirty1_in),
        .lru_write    (lru_write),
        .lru_in       (lru_in),
        .rwmux_sel    (rwmux_sel),
        .pmemmux_sel  (pmemmux_sel),
        .mem_rdata    (mem_rdata),
        .pmem_wdata   (pmem_wdata),
        .pmem_address (pmem_address),
        .hit          (hit),
        .way0and_out  (way0and_out),
        .lru_out      (lru_out),
        .dirtymux_out (dirtymux_out)
    );

endmodule : l2cache

/* tests/l2cache_assertions.sv */
`timescale 1ns/10ps

module l2cache_assertions
(
    input logic                        clk,
    input logic                        reset,
    input l2cache_pkg::l2cache_state_e state,
    input logic                        mem_resp,
    input logic                        pmem_read,
    input logic                        pmem_write,
    input logic                        data0write,
    input logic                        data1write,
    input logic                        tag0write,
    input logic                        tag1write,
    input logic                        valid0write,
    input logic                        valid1write,
    input logic                        dirty0write,
    input logic                        dirty1write
);

    // The upstream response lasts one cycle.
    resp_pulse: assert property (@(posedge clk) disable iff (reset) mem_resp |=> !mem_resp)
        else $error("mem_resp high for more than one cycle");

    pmem_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(pmem_read && pmem_write))
        else $error("pmem_read and pmem_write high together");

    // Only one way is written at a time.
    one_way_written: assert property (@(posedge clk) disable iff (reset)
        !(data0write && data1write) && !(tag0write && tag1write) &&
        !(valid0write && valid1write) && !(dirty0write && dirty1write))
        else $error("both ways written in one cycle");

    idle_after_reset: assert property (@(posedge clk) reset |=> state == l2cache_pkg::s_idle)
        else $error("controller not idle after reset");

endmodule : l2cache_assertions

bind l2cache_control l2cache_assertions control_checks
(
    .clk         (clk),
    .reset       (reset),
    .state       (state),
    .mem_resp    (mem_resp),
    .pmem_read   (pmem_read),
    .pmem_write  (pmem_write),
    .data0write  (data0write),
    .data1write  (data1write),
    .tag0write   (tag0write),
    .tag1write   (tag1write),
    .valid0write (valid0write),
    .valid1write (valid1write),
    .dirty0write (dirty0write),
    .dirty1write (dirty1write)
);

/* tests/l2cache_tb.sv */
`timescale 1ns/10ps
`include "l2cache_macros.svh"

module l2cache_tb;

    localparam int NUM_LINES     = 1 << (`L2_TAG_BITS + `L2_INDEX_BITS);
    localparam int NUM_RANDOM    = 400;
    localparam int NUM_DIRECTED  = 16;
    localparam int MAX_READBACK  = 48;
    localparam int CYCLES_PER_OP = 16;
    localparam int CYCLE_LIMIT   =
        (NUM_RANDOM + NUM_DIRECTED + MAX_READBACK) * CYCLES_PER_OP + 16;

    logic                   clk;
    logic                   reset;
    l2cache_pkg::l2_word    mem_address;
    logic                   mem_read;
    logic                   mem_write;
    l2cache_pkg::cache_line mem_wdata;
    l2cache_pkg::cache_line mem_rdata;
    logic                   mem_resp;
    l2cache_pkg::l2_word    pmem_address;
    logic                   pmem_read;
    logic                   pmem_write;
    l2cache_pkg::cache_line pmem_wdata;
    l2cache_pkg::cache_line pmem_rdata;
    logic                   pmem_resp;

    // Backing store of the memory model and the upstream view of every line.
    l2cache_pkg::cache_line backing [NUM_LINES];
    l2cache_pkg::cache_line shadow  [NUM_LINES];
    bit                     touched [NUM_LINES];

    // Reference cache state.
    l2cache_pkg::l2_tag     ref_tag   [2][`L2_SETS];
    bit                     ref_valid [2][`L2_SETS];
    bit                     ref_dirty [2][`L2_SETS];
    bit                     ref_lru   [`L2_SETS];

    // Request in flight and what it should cause.
    bit                     req_active;
    bit                     req_is_write;
    l2cache_pkg::l2_word    req_addr;
    bit                     exp_miss;
    bit                     exp_wb;
    l2cache_pkg::l2_word    exp_wb_addr;
    int                     fills_seen;
    int                     wbs_seen;
    int                     resp_count;
    int                     cycle_count;
    bit                     mem_busy;
    int unsigned            mem_wait;

    l2cache dut
    (
        .clk          (clk),
        .reset        (reset),
        .mem_address  (mem_address),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_address (pmem_address),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    always #50 clk = ~clk;

    function automatic int line_of(l2cache_pkg::l2_word addr);
        return int'(addr >> `L2_OFFSET_BITS);
    endfunction

    function automatic int set_of(l2cache_pkg::l2_word addr);
        return int'(addr[`L2_OFFSET_BITS +: `L2_INDEX_BITS]);
    endfunction

    function automatic l2cache_pkg::l2_tag tag_of(l2cache_pkg::l2_word addr);
        return addr[`L2_OFFSET_BITS+`L2_INDEX_BITS +: `L2_TAG_BITS];
    endfunction

    // Power-up memory contents are unique per word and per line address.
    function automatic l2cache_pkg::cache_line initial_line(int line);
        l2cache_pkg::cache_line value;
        value = '0;
        for (int i = 0; i < `L2_LINE_BITS/16; i++)
            value[i*16 +: 16] = {4'(i), 12'(line)};
        return value;
    endfunction

    function automatic l2cache_pkg::cache_line random_line();
        l2cache_pkg::cache_line value;
        value = '0;
        for (int i = 0; i < `L2_LINE_BITS/32; i++)
            value[i*32 +: 32] = $urandom;
        return value;
    endfunction

    // Four tags per set make evictions frequent.
    function automatic l2cache_pkg::l2_word random_addr();
        logic [31:0] r;
        r = $urandom;
        return {{4{r[1:0]}}, r[2 +: `L2_INDEX_BITS], r[8 +: `L2_OFFSET_BITS]};
    endfunction

    // Way holding the address, or -1 on a miss.
    function automatic int lookup_way(l2cache_pkg::l2_word addr);
        int set;
        set = set_of(addr);
        for (int w = 0; w < 2; w++)
            if (ref_valid[w][set] && ref_tag[w][set] == tag_of(addr))
                return w;
        return -1;
    endfunction

    function automatic l2cache_pkg::cache_line expected_line(l2cache_pkg::l2_word addr);
        return shadow[line_of(addr)];
    endfunction

    // True when a miss on addr must first write back a dirty LRU line.
    function automatic bit expected_victim(l2cache_pkg::l2_word addr,
                                           output l2cache_pkg::l2_word victim_addr);
        int set;
        int way;
        set = set_of(addr);
        way = ref_lru[set] ? 1 : 0;
        victim_addr = {ref_tag[way][set], addr[`L2_OFFSET_BITS +: `L2_INDEX_BITS],
                       {`L2_OFFSET_BITS{1'b0}}};
        if (lookup_way(addr) >= 0)
            return 1'b0;
        return ref_valid[way][set] && ref_dirty[way][set];
    endfunction

    function automatic void update_model(l2cache_pkg::l2_word addr, bit is_write,
                                         l2cache_pkg::cache_line data);
        int set;
        int way;
        set = set_of(addr);
        way = lookup_way(addr);
        if (way < 0)
        begin
            // Allocate into the LRU way as a clean line.
            way = ref_lru[set] ? 1 : 0;
            ref_tag[way][set]   = tag_of(addr);
            ref_valid[way][set] = 1'b1;
            ref_dirty[way][set] = 1'b0;
        end
        if (is_write)
        begin
            ref_dirty[way][set]   = 1'b1;
            shadow[line_of(addr)] = data;
        end
        // The other way becomes the victim.
        ref_lru[set] = (way == 0);
    endfunction

    task automatic abort_run(string text);
        $display("%s", text);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_line(l2cache_pkg::cache_line got, l2cache_pkg::cache_line exp,
                              string what);
        if (got !== exp)
            abort_run($sformatf("FAIL %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_addr(l2cache_pkg::l2_word got, l2cache_pkg::l2_word exp,
                              string what);
        if (got !== exp)
            abort_run($sformatf("FAIL %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    // Issue one request and hold it until the response has been checked.
    task automatic do_op(l2cache_pkg::l2_word addr, bit is_write,
                         l2cache_pkg::cache_line data);
        int                  start_count;
        l2cache_pkg::l2_word victim_addr;
        @(negedge clk);
        start_count  = resp_count;
        exp_miss     = (lookup_way(addr) < 0);
        exp_wb       = expected_victim(addr, victim_addr);
        exp_wb_addr  = victim_addr;
        fills_seen   = 0;
        wbs_seen     = 0;
        req_addr     = addr;
        req_is_write = is_write;
        req_active   = 1'b1;
        mem_address  = addr;
        mem_read     = !is_write;
        mem_write    = is_write;
        mem_wdata    = data;
        touched[line_of(addr)] = 1'b1;
        while (resp_count == start_count)
        begin
            @(negedge clk);
        end
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        req_active = 1'b0;
    endtask

    // Memory with a random latency of 1 to 4 cycles.
    always @(negedge clk)
    begin : memory_model
        if (reset)
        begin
            pmem_resp = 1'b0;
            mem_busy  = 1'b0;
        end
        else if (pmem_resp)
        begin
            pmem_resp = 1'b0;
            mem_busy  = 1'b0;
        end
        else if (pmem_read || pmem_write)
        begin
            if (!mem_busy)
            begin
                mem_busy = 1'b1;
                mem_wait = $urandom % 4;
            end
            if (mem_wait == 0)
            begin
                if (pmem_write)
                    backing[line_of(pmem_address)] = pmem_wdata;
                else
                    pmem_rdata = backing[line_of(pmem_address)];
                pmem_resp = 1'b1;
            end
            else
            begin
                mem_wait = mem_wait - 1;
            end
        end
    end

    // Outputs are sampled at the rising edge, before the DUT registers update.
    always @(posedge clk)
    begin : compare_responses
        l2cache_pkg::l2_word fill_addr;
        fill_addr = {req_addr[`L2_OFFSET_BITS +: `L2_TAG_BITS+`L2_INDEX_BITS],
                     {`L2_OFFSET_BITS{1'b0}}};
        if (!reset)
        begin
            if (mem_resp && !req_active)
                abort_run($sformatf("Error at %0t: response with no request", $time));
            if ((pmem_read || pmem_write) && (!req_active || !exp_miss))
                abort_run($sformatf("Error at %0t: memory access with no miss", $time));
            if (pmem_write && pmem_resp)
            begin
                if (!exp_wb || wbs_seen != 0 || fills_seen != 0)
                    abort_run($sformatf("Error at %0t: unexpected write-back", $time));
                check_addr(pmem_address, exp_wb_addr, "write-back address");
                check_line(pmem_wdata, shadow[line_of(exp_wb_addr)], "write-back data");
                wbs_seen = wbs_seen + 1;
            end
            if (pmem_read && pmem_resp)
            begin
                if (fills_seen != 0)
                    abort_run($sformatf("Error at %0t: second fill for one miss", $time));
                check_addr(pmem_address, fill_addr, "fill address");
                fills_seen = fills_seen + 1;
            end
            if (mem_resp)
            begin
                if (exp_miss && fills_seen != 1)
                    abort_run($sformatf("Error at %0t: miss answered without a fill", $time));
                if (exp_wb && wbs_seen != 1)
                    abort_run($sformatf("Error at %0t: dirty victim not written back",
                                        $time));
                if (!req_is_write)
                    check_line(mem_rdata, expected_line(req_addr), "read data");
                update_model(req_addr, req_is_write, mem_wdata);
                resp_count = resp_count + 1;
            end
        end
    end

    always @(posedge clk)
    begin : watchdog
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
            abort_run($sformatf("Timeout: no end of run after %0d cycles", cycle_count));
    end

    initial
    begin : stimulus
        l2cache_pkg::l2_word addr_a;
        logic [31:0]         coin;
        addr_a = 16'h1040;
        void'($urandom(37));
        clk         = 1'b0;
        reset       = 1'b1;
        mem_address = '0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_wdata   = '0;
        pmem_rdata  = '0;
        pmem_resp   = 1'b0;
        req_active  = 1'b0;
        resp_count  = 0;
        cycle_count = 0;
        mem_busy    = 1'b0;
        mem_wait    = 0;
        for (int i = 0; i < NUM_LINES; i++)
        begin
            backing[i] = initial_line(i);
            shadow[i]  = backing[i];
            touched[i] = 1'b0;
        end
        for (int s = 0; s < `L2_SETS; s++)
        begin
            ref_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++)
            begin
                ref_tag[w][s]   = '0;
                ref_valid[w][s] = 1'b0;
                ref_dirty[w][s] = 1'b0;
            end
        end

        repeat (4) @(negedge clk);
        reset = 1'b0;
        // Any response or memory access in these idle cycles is an error.
        repeat (3) @(negedge clk);

        // Read miss, read hit, write hit and write miss in set 2.
        do_op(addr_a, 1'b0, random_line());
        do_op(addr_a, 1'b0, random_line());
        do_op(addr_a + 16'd4, 1'b1, random_line());
        do_op(addr_a, 1'b0, random_line());
        do_op(16'h2048, 1'b1, random_line());
        do_op(16'h2040, 1'b0, random_line());
        // A third tag and then the first one again evict the dirty LRU lines in turn.
        do_op(16'h3050, 1'b0, random_line());
        do_op(addr_a, 1'b0, random_line());
        // Set 5 with clean lines only.
        do_op(16'h40a0, 1'b0, random_line());
        do_op(16'h50a4, 1'b0, random_line());
        do_op(16'h60b8, 1'b0, random_line());
        do_op(16'h40a0, 1'b0, random_line());

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            coin = $urandom;
            do_op(random_addr(), coin[0], random_line());
        end

        for (int i = 0; i < NUM_LINES; i++)
        begin
            if (touched[i])
                do_op(l2cache_pkg::l2_word'(i << `L2_OFFSET_BITS), 1'b0, random_line());
        end

        @(negedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule : l2cache_tb

/* flist.f */
+incdir+verilog
verilog/l2cache_pkg.sv
verilog/l2cache_data_array.sv
verilog/l2cache_datapath.sv
verilog/l2cache_control.sv
verilog/l2cache.sv
tests/l2cache_assertions.sv
tests/l2cache_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the L2 cache testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f flist.f --top-module l2cache_tb -o l2cache_sim

./obj_dir/l2cache_sim 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    exit 1
fi
exit 0
